// ==== rtl/lsu_geometry_pkg.sv ====
/*
  Address, bank and translation geometry of the load/store AGU.
  The line is 128 bytes wide, held in 32 banks of 4 bytes each.
*/
`default_nettype none

package lsu_geometry_pkg;

  // virtual address width, top bit marks the kernel half
  localparam int ADDR_W = 44;

  // bank geometry of one 128-byte line
  localparam int BANK_COUNT = 32;
  localparam int BANK_IDX_W = 5;

  // per-thread page base
  localparam int PAGE_BASE_W = 24;

  // translation tag is page base low bits above the virtual page number
  localparam int PAGE_TAG_W = 21;
  localparam int VPN_LSB    = 13;
  localparam int TLB_TAG_W  = PAGE_TAG_W + ADDR_W - VPN_LSB;

  typedef logic [ADDR_W-1:0]      addr_t;
  typedef logic [BANK_IDX_W-1:0]  bank_idx_t;
  typedef logic [BANK_COUNT-1:0]  bank_mask_t;
  typedef logic [PAGE_BASE_W-1:0] page_base_t;
  typedef logic [TLB_TAG_W-1:0]   tlb_tag_t;

  // two hardware threads
  typedef logic thread_t;

endpackage

`default_nettype wire

// ==== rtl/lsu_op_pkg.sv ====
/*
  Operation, thread context and lane result records of the AGU.
  Size codes 5 to 7 are not defined and decode as 8 bytes.
*/
`default_nettype none

package lsu_op_pkg;
  import lsu_geometry_pkg::*;

  typedef logic [2:0] size_code_t;
  typedef logic [8:0] lsq_tag_t;

  // access size codes
  localparam size_code_t SIZE_1B  = 3'd0;
  localparam size_code_t SIZE_2B  = 3'd1;
  localparam size_code_t SIZE_4B  = 3'd2;
  localparam size_code_t SIZE_8B  = 3'd3;
  localparam size_code_t SIZE_16B = 3'd4;

  // control-register field select
  localparam logic CSR_SEL_PAGE = 1'b0;
  localparam logic CSR_SEL_USER = 1'b1;

  typedef struct packed {
    logic       valid;
    logic       store;
    size_code_t size;
    addr_t      addr;
    thread_t    thread;
    lsq_tag_t   tag;
  } mem_op_t;

  typedef struct packed {
    page_base_t page_base;
    logic       user;
  } thread_ctx_t;

  typedef struct packed {
    logic       valid;
    logic       store;
    lsq_tag_t   tag;
    bank_mask_t bank_mask;
    bank_idx_t  first_bank;
    logic       split;
    logic       fault;
    logic       conflict;
    tlb_tag_t   tlb_tag;
  } lane_result_t;

endpackage

`default_nettype wire

// ==== rtl/agu_context_regs.sv ====
/*
  Page base and user bit for two threads, cleared by reset.
  Writes are not blocked by stall and are seen by ops on the next edge.
*/
`timescale 1ns/1ps
`default_nettype none

module agu_context_regs
  import lsu_geometry_pkg::*, lsu_op_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              csr_en,
  input  thread_t           csr_thread,
  input  logic              csr_sel,
  input  page_base_t        csr_data,
  output thread_ctx_t [1:0] ctx
);

  thread_ctx_t [1:0] ctx_q;

  // one field of one thread per strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      ctx_q <= '0;
    end else if (csr_en) begin
      case (csr_sel)
        CSR_SEL_PAGE: begin
          ctx_q[csr_thread].page_base <= csr_data;
        end
        CSR_SEL_USER: begin
          ctx_q[csr_thread].user <= csr_data[0];
        end
        default: begin
          ctx_q <= ctx_q;
        end
      endcase
    end
  end

  // shared by every lane
  assign ctx = ctx_q;

  // an unknown select would corrupt either field of the thread
  a_csr_sel_known: assert property (
    @(posedge clk) disable iff (rst)
    csr_en |-> !$isunknown(csr_sel)
  );

endmodule

`default_nettype wire

// ==== rtl/agu_lane.sv ====
/*
  One issue lane, result registered one cycle after the op is sampled.
  Conflict is left clear here and filled in by the arbiter.
*/
`timescale 1ns/1ps
`default_nettype none

module agu_lane
  import lsu_geometry_pkg::*, lsu_op_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              stall,
  input  mem_op_t           op,
  input  thread_ctx_t [1:0] ctx,
  output lane_result_t      result
);

  thread_ctx_t             op_ctx;
  bank_idx_t               first_bank;
  logic [4:0]              byte_count;
  logic [4:0]              span_sum;
  logic [2:0]              span;
  logic [BANK_IDX_W:0]     last_bank;
  bank_mask_t              span_mask;
  logic [2*BANK_COUNT-1:0] rot;
  lane_result_t            result_d;

  assign op_ctx     = ctx[op.thread];
  assign first_bank = op.addr[BANK_IDX_W+1:2];

  // size code to byte count
  always_comb begin
    case (op.size)
      SIZE_1B:  byte_count = 5'd1;
      SIZE_2B:  byte_count = 5'd2;
      SIZE_4B:  byte_count = 5'd4;
      SIZE_8B:  byte_count = 5'd8;
      SIZE_16B: byte_count = 5'd16;
      default:  byte_count = 5'd8;
    endcase
  end

  // banks touched, rounded up from the offset inside the first bank
  assign span_sum = {3'b000, op.addr[1:0]} + byte_count + 5'd3;
  assign span     = span_sum[4:2];

  // run of ones rotated up to the first bank, wrapping past bank 31
  assign span_mask = ~({BANK_COUNT{1'b1}} << span);
  assign rot       = {{BANK_COUNT{1'b0}}, span_mask} << first_bank;

  // carry out of the bank index means the access runs into the next line
  assign last_bank = {1'b0, first_bank} + {3'b000, span} - 6'd1;

  always_comb begin
    result_d            = '0;
    result_d.valid      = op.valid;
    result_d.store      = op.store;
    result_d.tag        = op.tag;
    result_d.bank_mask  = rot[BANK_COUNT-1:0] | rot[2*BANK_COUNT-1:BANK_COUNT];
    result_d.first_bank = first_bank;
    result_d.split      = last_bank[BANK_IDX_W];
    // user mode may not touch the upper half
    result_d.fault      = op_ctx.user && op.addr[ADDR_W-1];
    result_d.conflict   = 1'b0;
    result_d.tlb_tag    = {op_ctx.page_base[PAGE_TAG_W-1:0], op.addr[ADDR_W-1:VPN_LSB]};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result.valid <= 1'b0;
    end else if (!stall) begin
      result <= result_d;
    end
  end

  // a valid result always covers at least one bank
  a_valid_has_banks: assert property (
    @(posedge clk) disable iff (rst)
    result.valid |-> (result.bank_mask != '0)
  );

endmodule

`default_nettype wire

// ==== rtl/bank_conflict_arbiter.sv ====
/*
  Fixed priority by lane number, lane 0 always wins.
  A lane conflicts when its banks overlap any valid lower lane.
*/
`timescale 1ns/1ps
`default_nettype none

module bank_conflict_arbiter
  import lsu_geometry_pkg::*, lsu_op_pkg::*;
#(
  parameter int NUM_LANES = 3
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          stall,
  input  lane_result_t [NUM_LANES-1:0] lane_results,
  output lane_result_t [NUM_LANES-1:0] results
);

  lane_result_t [NUM_LANES-1:0] flagged;

  always_comb begin
    bank_mask_t lower_union;
    lower_union = '0;
    for (int k = 0; k < NUM_LANES; k++) begin
      flagged[k] = lane_results[k];
      flagged[k].conflict = (k > 0) && lane_results[k].valid &&
                            ((lane_results[k].bank_mask & lower_union) != '0);
      // invalid lanes claim no banks
      if (lane_results[k].valid) begin
        lower_union = lower_union | lane_results[k].bank_mask;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < NUM_LANES; k++) begin
        results[k].valid <= 1'b0;
      end
    end else if (!stall) begin
      results <= flagged;
    end
  end

  a_lane0_no_conflict: assert property (
    @(posedge clk) disable iff (rst)
    results[0].valid |-> !results[0].conflict
  );

endmodule

`default_nettype wire

// ==== rtl/agu_top.sv ====
/*
  Results appear two rising edges after ops are sampled.
  Stall freezes both stages, NUM_LANES may be 1 to 4.
*/
`timescale 1ns/1ps
`default_nettype none

module agu_top
  import lsu_geometry_pkg::*, lsu_op_pkg::*;
#(
  parameter int NUM_LANES = 3
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          stall,
  input  logic                          csr_en,
  input  thread_t                       csr_thread,
  input  logic                          csr_sel,
  input  page_base_t                    csr_data,
  input  mem_op_t      [NUM_LANES-1:0] ops,
  output lane_result_t [NUM_LANES-1:0] results
);

  thread_ctx_t  [1:0]           ctx;
  lane_result_t [NUM_LANES-1:0] lane_results;

  agu_context_regs ctx_regs_inst (
    .clk        (clk),
    .rst        (rst),
    .csr_en     (csr_en),
    .csr_thread (csr_thread),
    .csr_sel    (csr_sel),
    .csr_data   (csr_data),
    .ctx        (ctx)
  );

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    agu_lane lane_inst (
      .clk    (clk),
      .rst    (rst),
      .stall  (stall),
      .op     (ops[g]),
      .ctx    (ctx),
      .result (lane_results[g])
    );
  end

  bank_conflict_arbiter #(
    .NUM_LANES (NUM_LANES)
  ) arbiter_inst (
    .clk          (clk),
    .rst          (rst),
    .stall        (stall),
    .lane_results (lane_results),
    .results      (results)
  );

endmodule

`default_nettype wire

// ==== verification/agu_checker.sv ====
/*
  Compares DUT results with queued expected records, two unstalled edges after issue.
  Also flags any change of the results across a stalled edge.
*/
`timescale 1ns/1ps
`default_nettype none

module agu_checker
  import lsu_geometry_pkg::*, lsu_op_pkg::*;
#(
  parameter int NUM_LANES = 3
) (
  input logic                         clk,
  input logic                         rst,
  input logic                         stall,
  input logic                         issue,
  input lane_result_t [NUM_LANES-1:0] results
);

  typedef lane_result_t [NUM_LANES-1:0] lane_set_t;

  string     name_q[$];
  lane_set_t exp_q[$];
  int        checked = 0;
  int        fail_count = 0;
  int        other_errors = 0;
  logic      in_stage = 1'b0;
  logic      arrived = 1'b0;
  logic      stall_q = 1'b0;
  logic      live = 1'b0;
  lane_set_t prev;

  task automatic push_expected(input string name, input lane_set_t exp);
    name_q.push_back(name);
    exp_q.push_back(exp);
  endtask

  // mirror of the two pipeline stages
  always @(posedge clk) begin
    stall_q <= stall;
    live <= !rst;
    prev <= results;
    if (rst) begin
      in_stage <= 1'b0;
      arrived <= 1'b0;
    end else if (stall) begin
      arrived <= 1'b0;
    end else begin
      in_stage <= issue;
      arrived <= in_stage;
    end
  end

  always @(negedge clk) begin
    string     name;
    lane_set_t exp;
    logic      bad;
    if (live && stall_q && results !== prev) begin
      other_errors++;
      $display("results changed on a clock edge while the pipeline was stalled");
    end
    if (live && arrived) begin
      name = name_q.pop_front();
      exp = exp_q.pop_front();
      bad = 1'b0;
      for (int k = 0; k < NUM_LANES; k++) begin
        if (results[k].valid !== exp[k].valid ||
            (exp[k].valid && results[k] !== exp[k])) begin
          bad = 1'b1;
          $display("[FAIL] %s lane %0d expected %h actual %h", name, k, exp[k], results[k]);
        end
      end
      if (bad) fail_count++;
      else $display("[PASS] %s", name);
      checked++;
    end
  end

endmodule

`default_nettype wire

// ==== verification/agu_tb.sv ====
/*
  Testbench for agu_top with three lanes, driven from the golden file.
  Tags come from an xorshift generator and are placed into the expected records.
*/
`timescale 1ns/1ps
`default_nettype none

module agu_tb
  import lsu_geometry_pkg::*, lsu_op_pkg::*;
;
  localparam int NUM_LANES = 3;
  localparam int MAX_TESTS = 16;

  logic                         clk = 1'b0;
  logic                         rst = 1'b1;
  logic                         stall = 1'b0;
  logic                         csr_en = 1'b0;
  thread_t                      csr_thread = 1'b0;
  logic                         csr_sel = 1'b0;
  page_base_t                   csr_data = '0;
  mem_op_t      [NUM_LANES-1:0] ops = '0;
  lane_result_t [NUM_LANES-1:0] results;
  logic                         issue = 1'b0;

  string        test_name [MAX_TESTS];
  logic [2:0]   test_csr [MAX_TESTS];
  page_base_t   test_data [MAX_TESTS];
  int           test_stall [MAX_TESTS];
  mem_op_t      op_mem [MAX_TESTS*NUM_LANES];
  lane_result_t exp_mem [MAX_TESTS*NUM_LANES];
  int           n_tests = 0;
  int           cycles = 0;
  int           limit = 1000;
  logic [31:0]  rand_state = 32'd29;

  always #2 clk = ~clk;

  agu_top #(.NUM_LANES(NUM_LANES)) agu_top_inst (
    .clk(clk), .rst(rst), .stall(stall), .csr_en(csr_en), .csr_thread(csr_thread),
    .csr_sel(csr_sel), .csr_data(csr_data), .ops(ops), .results(results)
  );

  agu_checker #(.NUM_LANES(NUM_LANES)) checker_inst (
    .clk(clk), .rst(rst), .stall(stall), .issue(issue), .results(results)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // T lines open a test, L lines give one lane each
  task automatic load_tests(input int fd);
    string tok;
    string skip;
    int code;
    int idx;
    logic v, st, sp, ft, cf, ce, ct, cs;
    size_code_t sz;
    addr_t addr;
    thread_t th;
    bank_mask_t mask;
    bank_idx_t fb;
    tlb_tag_t tlb;
    idx = 0;
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", tok);
      if (code != 1) break;
      if (tok == "T") begin
        code = $fscanf(fd, "%s %h %h %h %h %d", test_name[n_tests], ce, ct, cs,
                       test_data[n_tests], test_stall[n_tests]);
        test_csr[n_tests] = {ce, ct, cs};
        idx = n_tests * NUM_LANES;
        n_tests++;
      end else if (tok == "L") begin
        code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h",
                       v, st, sz, addr, th, mask, fb, sp, ft, cf, tlb);
        op_mem[idx] = '{valid: v, store: st, size: sz, addr: addr, thread: th, tag: '0};
        exp_mem[idx] = '{valid: v, store: st, tag: '0, bank_mask: mask, first_bank: fb,
                         split: sp, fault: ft, conflict: cf, tlb_tag: tlb};
        idx++;
      end else begin
        code = $fgets(skip, fd);
      end
    end
  endtask

  task automatic run_test(input int t);
    lane_result_t [NUM_LANES-1:0] exp;
    if (test_csr[t][2]) begin
      csr_en = 1'b1;
      csr_thread = test_csr[t][1];
      csr_sel = test_csr[t][0];
      csr_data = test_data[t];
      @(negedge clk);
      csr_en = 1'b0;
    end
    for (int k = 0; k < NUM_LANES; k++) begin
      rand_state = xorshift(rand_state);
      ops[k] = op_mem[t*NUM_LANES+k];
      ops[k].tag = rand_state[8:0];
      exp[k] = exp_mem[t*NUM_LANES+k];
      exp[k].tag = rand_state[8:0];
    end
    checker_inst.push_expected(test_name[t], exp);
    issue = 1'b1;
    @(negedge clk);
    ops = '0;
    issue = 1'b0;
    stall = (test_stall[t] > 0);
    repeat (test_stall[t]) @(negedge clk);
    stall = 1'b0;
    while (checker_inst.checked < t + 1) @(negedge clk);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("timeout: results did not arrive within %0d cycles", limit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    int fd;
    fd = $fopen("verification/agu_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open the golden file verification/agu_golden.txt");
      $display("*** FAILED ***");
      $finish;
    end else begin
      load_tests(fd);
      $fclose(fd);
      limit = n_tests * 6 + 20;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      for (int t = 0; t < n_tests; t++) begin
        run_test(t);
      end
      $display("tests passed: %0d, failed: %0d, other errors: %0d",
               checker_inst.checked - checker_inst.fail_count, checker_inst.fail_count,
               checker_inst.other_errors);
      if (checker_inst.fail_count == 0 && checker_inst.other_errors == 0 && n_tests > 0) begin
        $display("*** PASSED ***");
      end else begin
        $display("*** FAILED ***");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== verification/agu_golden.txt ====
# T name csr_en csr_thread csr_sel csr_data stall_cycles
# L valid store size addr thread | expect mask first_bank split fault conflict tlb_tag
T mask_sizes 0 0 0 000000 0
L 1 0 0 00000000001 0 00000001 00 0 0 0 0000000000000
L 1 0 2 00000000006 0 00000006 01 0 0 0 0000000000000
L 1 1 4 00000000020 0 00000f00 08 0 0 0 0000000000000
T split_wrap 0 0 0 000000 0
L 1 0 3 0000000007c 0 80000001 1f 1 0 0 0000000000000
L 0 0 4 00000000010 0 00000000 00 0 0 0 0000000000000
L 1 1 2 000000001fc 0 80000000 1f 0 0 1 0000000000000
T fault_user 1 1 1 000001 0
L 0 0 0 80000000040 1 00000000 00 0 0 0 0000000000000
L 1 0 5 80000000042 0 00070000 10 0 0 0 0000040000000
L 1 1 1 80000000043 1 00030000 10 0 1 1 0000040000000
T fault_clear 1 1 1 000000 0
L 1 0 2 80000000000 1 00000001 00 0 0 0 0000040000000
L 1 0 0 80000000004 1 00000002 01 0 0 0 0000040000000
L 0 0 0 00000000000 0 00000000 00 0 0 0 0000000000000
T tag_thread0 1 0 0 abcdef 0
L 1 0 2 00000004000 0 00000001 00 0 0 0 5e6f780000002
L 1 1 2 00000002080 1 00000001 00 0 0 1 0000000000001
L 1 0 0 00000000008 0 00000004 02 0 0 0 5e6f780000000
T tag_thread1_stall 1 1 0 123456 3
L 1 0 3 0000000600c 1 00000018 03 0 0 0 91a2b00000003
L 1 0 2 0000000000c 0 00000008 03 0 0 1 5e6f780000000
L 1 1 4 00000000070 1 f0000000 1c 0 0 0 91a2b00000000

// ==== compile.f ====
rtl/lsu_geometry_pkg.sv
rtl/lsu_op_pkg.sv
rtl/agu_context_regs.sv
rtl/agu_lane.sv
rtl/bank_conflict_arbiter.sv
rtl/agu_top.sv
verification/agu_checker.sv
verification/agu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module agu_tb -f compile.f \
  --Mdir obj_dir -o agu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/agu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qF "*** FAILED ***" sim.log; then
  exit 1
fi
exit 0
